// File: project.f
+incdir+design
design/shalu_pkg.sv
design/arb_rr.sv
design/issue_stage.sv
design/acc_regfile.sv
design/operand_read.sv
design/alu_exec.sv
design/shalu_top.sv
test/shalu_asserts.sv
test/tb_shalu.sv

// File: Makefile
# Verilator build for the shared arithmetic unit testbench

SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_shalu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_shalu.sv
// Self-checking testbench for the shared arithmetic unit.
// Four requester models issue 400 LFSR-driven commands from a fixed seed.
// Outputs are sampled at the falling edge, where they are stable, and compared
// with a model of the round-robin and register rules.
// The first mismatch or a timeout ends the run with $fatal.

`default_nettype none

`include "shalu_consts.svh"

module tb_shalu
  import shalu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_cmds       = 400;
  localparam int timeout_cycles = num_cmds * 12 + 100;
  localparam int reset_cycles   = 3;

  logic                      clk;
  logic                      reset;
  logic                      rotate_en;
  logic [`SHALU_NUM_REQ-1:0] request;
  cmd_t                      cmd [`SHALU_NUM_REQ];
  logic [`SHALU_NUM_REQ-1:0] grant;
  resp_t                     resp;

  // Model and requester state
  logic [31:0]               lfsr_state;
  logic [`SHALU_DATA_W-1:0]  model_regs [`SHALU_NUM_REGS];
  logic [`SHALU_REQ_W-1:0]   model_last;
  logic [`SHALU_NUM_REQ-1:0] granted_q;
  logic [`SHALU_REG_W-1:0]   last_dst;
  resp_t                     exp_q [$];
  int                        grant_cycle_q [$];
  int                        wait_cnt [`SHALU_NUM_REQ];
  int                        cycle;
  int                        issued;
  int                        completed;

  shalu_top shalu_top_i (
    .clk       (clk),
    .reset     (reset),
    .rotate_en (rotate_en),
    .request   (request),
    .cmd       (cmd),
    .grant     (grant),
    .resp      (resp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ------------------------------
  // Random source
  // ------------------------------

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One step per bit taken, newest bit lands in the LSB
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_advance(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // About half the commands read the register the previous one writes,
  // which builds dependency chains at distance 1 and 2
  function automatic cmd_t random_cmd();
    cmd_t        c;
    logic [31:0] bits;
    bits  = random_bits(2);
    c.op  = op_e'(bits[1:0]);
    c.dst = `SHALU_REG_W'(random_bits(`SHALU_REG_W));
    if (random_bits(1) == 32'd1) begin
      c.src = last_dst;
    end else begin
      c.src = `SHALU_REG_W'(random_bits(`SHALU_REG_W));
    end
    c.imm    = `SHALU_DATA_W'(random_bits(`SHALU_DATA_W));
    last_dst = c.dst;
    return c;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------

  // Walks the requesters from the one after the last grant, wrapping around
  function automatic logic [`SHALU_NUM_REQ-1:0] expected_grant(
    input logic [`SHALU_NUM_REQ-1:0] req,
    input logic [`SHALU_REQ_W-1:0]   last
  );
    logic [`SHALU_NUM_REQ-1:0] pick;
    int                        idx;
    pick = '0;
    for (int k = `SHALU_NUM_REQ; k >= 1; k--) begin
      idx = (int'(last) + k) % `SHALU_NUM_REQ;
      if (req[idx]) begin
        pick      = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic int grant_to_index(input logic [`SHALU_NUM_REQ-1:0] g);
    int idx;
    idx = 0;
    for (int i = 0; i < `SHALU_NUM_REQ; i++) begin
      if (g[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Commands take effect in grant order, so the model updates at the grant
  function automatic resp_t apply_cmd(input int id, input cmd_t c);
    resp_t                    r;
    logic [`SHALU_DATA_W-1:0] a;
    a = model_regs[c.src];
    case (c.op)
      OP_LOAD: r.result = c.imm;
      OP_ADD:  r.result = a + c.imm;
      OP_SUB:  r.result = a - c.imm;
      default: r.result = a ^ c.imm;
    endcase
    r.valid            = 1'b1;
    r.req_id           = `SHALU_REQ_W'(id);
    r.dst              = c.dst;
    model_regs[c.dst]  = r.result;
    return r;
  endfunction

  // ------------------------------
  // Checks
  // ------------------------------

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  task automatic check_grant(
    input logic [`SHALU_NUM_REQ-1:0] exp,
    input logic [`SHALU_NUM_REQ-1:0] act
  );
    if (act !== exp) begin
      report_failure($sformatf("** Error: grant expected 0x%h, got 0x%h in cycle %0d",
        exp, act, cycle));
    end
  endtask

  task automatic check_resp(input resp_t exp, input resp_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error: resp expected 0x%h, got 0x%h in cycle %0d",
        exp, act, cycle));
    end
  endtask

  always @(posedge clk) begin : count_cycles
    cycle = cycle + 1;
    if (cycle >= timeout_cycles) begin
      report_failure($sformatf("Timeout after %0d cycles with %0d of %0d commands done",
        cycle, completed, num_cmds));
    end
  end

  always @(negedge clk) begin : compare_outputs
    logic [`SHALU_NUM_REQ-1:0] exp_grant;
    int                        gidx;
    if (reset) begin
      model_last = `SHALU_REQ_W'(`SHALU_NUM_REQ - 1);
      granted_q  = '0;
      for (int i = 0; i < `SHALU_NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
    end else begin
      exp_grant = expected_grant(request, model_last);
      check_grant(exp_grant, grant);
      granted_q = grant;
      // Responses are checked before this cycle's grant joins the queue
      if (resp.valid && exp_q.size() == 0) begin
        report_failure($sformatf("Response in cycle %0d with no grant pending", cycle));
      end else if (resp.valid && grant_cycle_q[0] + 3 != cycle) begin
        report_failure($sformatf("Response in cycle %0d, expected in cycle %0d",
          cycle, grant_cycle_q[0] + 3));
      end else if (grant_cycle_q.size() > 0 && grant_cycle_q[0] + 3 == cycle) begin
        check_resp(exp_q.pop_front(), resp);
        void'(grant_cycle_q.pop_front());
        completed++;
      end
      if (|grant) begin
        gidx = grant_to_index(grant);
        exp_q.push_back(apply_cmd(gidx, cmd[gidx]));
        grant_cycle_q.push_back(cycle);
        if (rotate_en) begin
          model_last = `SHALU_REQ_W'(gidx);
        end
      end
    end
  end

  // ------------------------------
  // Requester models
  // ------------------------------

  // A granted requester drops out for 0 to 3 cycles before its next command
  task automatic update_requesters();
    for (int i = 0; i < `SHALU_NUM_REQ; i++) begin
      if (request[i] && granted_q[i]) begin
        request[i]  = 1'b0;
        wait_cnt[i] = int'(random_bits(2));
      end
      if (!request[i]) begin
        if (wait_cnt[i] > 0) begin
          wait_cnt[i]--;
        end else if (issued < num_cmds) begin
          cmd[i]     = random_cmd();
          request[i] = 1'b1;
          issued++;
        end
      end
    end
  endtask

  initial begin : drive_stimulus
    lfsr_state = 32'hfe7cd054;
    reset      = 1'b1;
    rotate_en  = 1'b1;
    request    = '0;
    last_dst   = '0;
    cycle      = 0;
    issued     = 0;
    completed  = 0;
    for (int i = 0; i < `SHALU_NUM_REQ; i++) begin
      cmd[i]      = '0;
      wait_cnt[i] = 0;
    end
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;
    // All four raise at once here, so the first grants show the plain rotation
    while (issued < num_cmds || request != '0) begin
      if (issued >= 200 && issued < 240) begin
        rotate_en = 1'b0;
      end else if (cycle < reset_cycles + 8) begin
        rotate_en = 1'b1;
      end else begin
        rotate_en = (random_bits(3) != 32'd0);
      end
      update_requesters();
      @(posedge clk);
      #2;
    end
    // Drain the pipeline, then watch a few idle cycles for stray responses
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (completed != num_cmds || exp_q.size() != 0) begin
      report_failure($sformatf("Only %0d of %0d commands completed", completed, num_cmds));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule : tb_shalu

`default_nettype wire

// File: test/shalu_asserts.sv
// Concurrent checks on the arbiter outputs and the response timing.
// Bound into shalu_top, where the arbiter ports are visible as top-level nets.
// The response check relies on the fixed three-cycle pipeline with no stalls.

`default_nettype none

`include "shalu_consts.svh"

module shalu_asserts
  import shalu_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`SHALU_NUM_REQ-1:0] request,
  input  logic [`SHALU_NUM_REQ-1:0] grant,
  input  resp_t                     resp
);

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Arbiter
  // ------------------------------

  grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else $error("grant 0x%h has more than one bit set", grant);

  // A grant may only go to a requester that is asking
  grant_subset: assert property (@(posedge clk) disable iff (reset)
    (grant & ~request) == '0)
    else $error("grant 0x%h not covered by request 0x%h", grant, request);

  grant_present: assert property (@(posedge clk) disable iff (reset) |request |-> |grant)
    else $error("request 0x%h left without a grant", request);

  // ------------------------------
  // Response
  // ------------------------------

  // Issue, operand read and execute give exactly three cycles of latency
  resp_after_grant: assert property (@(posedge clk) disable iff (reset)
    resp.valid |-> $past(|grant, 3))
    else $error("response for requester %0d without a grant three cycles before",
      resp.req_id);

endmodule : shalu_asserts

bind shalu_top shalu_asserts shalu_asserts_i (
  .clk     (clk),
  .reset   (reset),
  .request (request),
  .grant   (grant),
  .resp    (resp)
);

`default_nettype wire

// File: design/shalu_top.sv
// Shared arithmetic unit for four requesters.
// Requests are levels and grants are pulses with no handshake.
// A response appears three cycles after its grant and must be taken then,
// since there is no back-pressure anywhere in the pipeline.

`default_nettype none

`include "shalu_consts.svh"

module shalu_top
  import shalu_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rotate_en,
  input  logic [`SHALU_NUM_REQ-1:0] request,
  input  cmd_t                      cmd [`SHALU_NUM_REQ],
  output logic [`SHALU_NUM_REQ-1:0] grant,
  output resp_t                     resp
);

  issue_t                   issue;
  exec_t                    exe;
  resp_t                    fwd;
  logic [`SHALU_REG_W-1:0]  rd_addr;
  logic [`SHALU_DATA_W-1:0] rd_data;
  logic                     wr_en;
  logic [`SHALU_REG_W-1:0]  wr_addr;
  logic [`SHALU_DATA_W-1:0] wr_data;

  // ------------------------------
  // Arbitration and issue
  // ------------------------------

  arb_rr arb_rr_i (
    .clk       (clk),
    .reset     (reset),
    .rotate_en (rotate_en),
    .request   (request),
    .grant     (grant)
  );

  issue_stage issue_stage_i (
    .clk   (clk),
    .reset (reset),
    .grant (grant),
    .cmd   (cmd),
    .issue (issue)
  );

  // ------------------------------
  // Operands and register file
  // ------------------------------

  operand_read operand_read_i (
    .clk     (clk),
    .reset   (reset),
    .issue   (issue),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .fwd     (fwd),
    .exe     (exe)
  );

  acc_regfile acc_regfile_i (
    .clk     (clk),
    .reset   (reset),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // Execute closes the loop back to the register file and the operand stage
  alu_exec alu_exec_i (
    .clk     (clk),
    .reset   (reset),
    .exe     (exe),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .fwd     (fwd),
    .resp    (resp)
  );

endmodule : shalu_top

`default_nettype wire

// File: design/alu_exec.sv
// Execute stage, which computes the result and writes it back.
// The register write is presented in this cycle and lands at the next edge,
// the same edge that makes the registered response valid.
// fwd carries the unregistered result back to the operand stage.

`default_nettype none

`include "shalu_consts.svh"

module alu_exec
  import shalu_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  exec_t                    exe,
  output logic                     wr_en,
  output logic [`SHALU_REG_W-1:0]  wr_addr,
  output logic [`SHALU_DATA_W-1:0] wr_data,
  output resp_t                    fwd,
  output resp_t                    resp
);

  logic [`SHALU_DATA_W-1:0] result;
  resp_t                    resp_q;

  // ------------------------------
  // Arithmetic
  // ------------------------------

  // Add and subtract wrap modulo 2^16
  always_comb begin
    result = exe.imm;
    unique case (exe.op)
      OP_LOAD: result = exe.imm;
      OP_ADD:  result = exe.a + exe.imm;
      OP_SUB:  result = exe.a - exe.imm;
      OP_XOR:  result = exe.a ^ exe.imm;
    endcase
  end

  // Write port driven straight from the stage
  assign wr_en   = exe.valid;
  assign wr_addr = exe.dst;
  assign wr_data = result;

  // Same content the response will carry, one cycle early
  always_comb begin
    fwd.valid  = exe.valid;
    fwd.req_id = exe.req_id;
    fwd.dst    = exe.dst;
    fwd.result = result;
  end

  // ------------------------------
  // Response register
  // ------------------------------

  // A response lasts exactly one cycle because the stage never holds
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_q.valid <= 1'b0;
    end else begin
      resp_q <= fwd;
    end
  end

  assign resp = resp_q;

endmodule : alu_exec

`default_nettype wire

// File: design/operand_read.sv
// Operand read stage, the second register of the pipeline.
// Forwarding covers only the command one ahead, which is in execute.
// The command two ahead has already written the register file by then.

`default_nettype none

`include "shalu_consts.svh"

module operand_read
  import shalu_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  issue_t                   issue,
  output logic [`SHALU_REG_W-1:0]  rd_addr,
  input  logic [`SHALU_DATA_W-1:0] rd_data,
  input  resp_t                    fwd,
  output exec_t                    exe
);

  logic                     fwd_hit;
  logic [`SHALU_DATA_W-1:0] operand;
  exec_t                    exe_next;
  exec_t                    exe_q;

  // ------------------------------
  // Operand select
  // ------------------------------

  assign rd_addr = issue.cmd.src;

  // The execute stage writes this register at the coming edge
  // Its value is not yet in the file, so take it straight from the ALU
  assign fwd_hit = fwd.valid && (fwd.dst == issue.cmd.src);
  assign operand = fwd_hit ? fwd.result : rd_data;

  always_comb begin
    exe_next.valid  = issue.valid;
    exe_next.req_id = issue.req_id;
    exe_next.op     = issue.cmd.op;
    exe_next.dst    = issue.cmd.dst;
    exe_next.a      = operand;
    exe_next.imm    = issue.cmd.imm;
  end

  // ------------------------------
  // Operand register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      exe_q.valid <= 1'b0;
    end else begin
      exe_q <= exe_next;
    end
  end

  assign exe = exe_q;

endmodule : operand_read

`default_nettype wire

// File: design/acc_regfile.sv
// Accumulator register file with one read port and one write port.
// The read is combinational and shows the old value during a write cycle,
// so the stage that reads must forward from the writer itself.
// All registers read zero after reset.

`default_nettype none

`include "shalu_consts.svh"

module acc_regfile (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`SHALU_REG_W-1:0]  rd_addr,
  output logic [`SHALU_DATA_W-1:0] rd_data,
  input  logic                     wr_en,
  input  logic [`SHALU_REG_W-1:0]  wr_addr,
  input  logic [`SHALU_DATA_W-1:0] wr_data
);

  logic [`SHALU_DATA_W-1:0] regs [`SHALU_NUM_REGS];

  // Architectural state, so every entry is cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `SHALU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Read port has no bypass
  assign rd_data = regs[rd_addr];

endmodule : acc_regfile

`default_nettype wire

// File: design/issue_stage.sv
// Issue stage, the first register of the pipeline.
// Expects a one-hot or zero grant vector from the arbiter.
// A zero grant loads an invalid entry, so the stage never stalls.

`default_nettype none

`include "shalu_consts.svh"

module issue_stage
  import shalu_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`SHALU_NUM_REQ-1:0] grant,
  input  cmd_t                      cmd [`SHALU_NUM_REQ],
  output issue_t                    issue
);

  logic [`SHALU_REQ_W-1:0] grant_idx;
  issue_t                  issue_next;
  issue_t                  issue_q;

  // ------------------------------
  // Command select
  // ------------------------------

  // The index doubles as the tag that comes back with the response
  assign grant_idx = onehot_to_idx(grant);

  always_comb begin
    issue_next.valid  = |grant;
    issue_next.req_id = grant_idx;
    // With no grant this selects requester 0, which the valid bit masks off
    issue_next.cmd    = cmd[grant_idx];
  end

  // ------------------------------
  // Issue register
  // ------------------------------

  // Only the valid bit is control state
  // The payload simply follows the select
  always_ff @(posedge clk) begin
    if (reset) begin
      issue_q.valid <= 1'b0;
    end else begin
      issue_q <= issue_next;
    end
  end

  assign issue = issue_q;

endmodule : issue_stage

`default_nettype wire

// File: design/arb_rr.sv
// Round-robin arbiter for the shared unit, zero latency from request to grant.
// Requester 0 has the highest priority out of reset.
// Requesters must hold their request until granted for fairness to hold.
// With rotate_en low a grant is still made but the priority stays put.

`default_nettype none

`include "shalu_consts.svh"

module arb_rr
  import shalu_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rotate_en,
  input  logic [`SHALU_NUM_REQ-1:0] request,
  output logic [`SHALU_NUM_REQ-1:0] grant
);

  // Keeps only the lowest set bit of a vector, so index 0 wins ties
  function automatic logic [`SHALU_NUM_REQ-1:0] lowest_set(
    input logic [`SHALU_NUM_REQ-1:0] vec
  );
    logic [`SHALU_NUM_REQ-1:0] pick;
    logic                      found;
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < `SHALU_NUM_REQ; i++) begin
      if (vec[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
    return pick;
  endfunction

  logic [`SHALU_NUM_REQ-1:0] priority_mask;
  logic [`SHALU_NUM_REQ-1:0] request_high;
  logic [`SHALU_NUM_REQ-1:0] grant_high;
  logic [`SHALU_NUM_REQ-1:0] grant_low;
  logic [`SHALU_REQ_W-1:0]   last_grant;
  logic [`SHALU_REQ_W-1:0]   last_grant_next;

  // ------------------------------
  // Priority selection
  // ------------------------------

  // Indices above the last grant are ahead of the wrap point
  always_comb begin
    for (int i = 0; i < `SHALU_NUM_REQ; i++) begin
      priority_mask[i] = (i > last_grant);
    end
  end

  assign request_high = request & priority_mask;

  // First pick searches before the wrap, the second covers the wrapped order
  assign grant_high = lowest_set(request_high);
  // No mask needed here since this pick is used only when request_high is empty
  assign grant_low  = lowest_set(request);

  assign grant = (|request_high) ? grant_high : grant_low;

  // ------------------------------
  // Last-grant state
  // ------------------------------

  assign last_grant_next = onehot_to_idx(grant);

  // Any request yields a grant, so the request vector alone qualifies the load
  // Starting at the top index puts requester 0 first after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= `SHALU_REQ_W'(`SHALU_NUM_REQ - 1);
    end else if (rotate_en && (|request)) begin
      last_grant <= last_grant_next;
    end
  end

endmodule : arb_rr

`default_nettype wire

// File: design/shalu_pkg.sv
// Types shared by the arbiter, the pipeline stages and the testbench.
// Field widths follow the defines in the constants header.
// The one-hot helper expects at most one bit set in its input.

`default_nettype none

`include "shalu_consts.svh"

package shalu_pkg;

  // Operation codes carried by every command
  typedef enum logic [1:0] {
    OP_LOAD = 2'd0,
    OP_ADD  = 2'd1,
    OP_SUB  = 2'd2,
    OP_XOR  = 2'd3
  } op_e;

  // Command as presented by a requester while it waits for its grant
  typedef struct packed {
    op_e                      op;
    logic [`SHALU_REG_W-1:0]  dst;
    logic [`SHALU_REG_W-1:0]  src;
    logic [`SHALU_DATA_W-1:0] imm;
  } cmd_t;

  // Contents of the issue register
  typedef struct packed {
    logic                    valid;
    logic [`SHALU_REQ_W-1:0] req_id;
    cmd_t                    cmd;
  } issue_t;

  // Contents of the operand register, with the source value already resolved
  typedef struct packed {
    logic                     valid;
    logic [`SHALU_REQ_W-1:0]  req_id;
    op_e                      op;
    logic [`SHALU_REG_W-1:0]  dst;
    logic [`SHALU_DATA_W-1:0] a;
    logic [`SHALU_DATA_W-1:0] imm;
  } exec_t;

  // Response returned to the requester named by req_id
  typedef struct packed {
    logic                     valid;
    logic [`SHALU_REQ_W-1:0]  req_id;
    logic [`SHALU_REG_W-1:0]  dst;
    logic [`SHALU_DATA_W-1:0] result;
  } resp_t;

  // Converts a one-hot or zero requester vector to its index
  // A zero vector maps to index 0
  function automatic logic [`SHALU_REQ_W-1:0] onehot_to_idx(
    input logic [`SHALU_NUM_REQ-1:0] oh
  );
    logic [`SHALU_REQ_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < `SHALU_NUM_REQ; i++) begin
      if (oh[i]) begin
        idx = idx | `SHALU_REQ_W'(i);
      end
    end
    return idx;
  endfunction

endpackage : shalu_pkg

`default_nettype wire

// File: design/shalu_consts.svh
// Sizing constants for the shared arithmetic unit.
// The requester count is fixed at 4 because the command mux and the
// round-robin index logic rely on a 2-bit requester index.
// Index widths must stay consistent with the counts below.

`ifndef SHALU_CONSTS_SVH
`define SHALU_CONSTS_SVH

// Number of requesters sharing the unit
`define SHALU_NUM_REQ 4

// Number of accumulator registers
`define SHALU_NUM_REGS 8

// Width of register contents, immediates and results
`define SHALU_DATA_W 16

// Width of a register index, log2 of the register count
`define SHALU_REG_W 3

// Width of a requester index, log2 of the requester count
`define SHALU_REQ_W 2

`endif
